// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_flash_boot
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
flash_pkg.sv
flash_stream_if.sv
flash_fast_read.sv
flash_image_check.sv
flash_boot_top.sv
spi_flash_model.sv
flash_boot_props.sv
tb_flash_boot.sv

// File: flash_boot_props.sv
`timescale 1ns/1ps

// SPI pin and stream rules for flash_boot_top
module flash_boot_props (
    input logic clk,
    input logic rst_n,
    input logic fls_sck,
    input logic fls_ncs,
    input logic busy,
    input logic byte_valid,
    input logic done
);

    // Count of failed properties
    int fail_cnt = 0;

    // Deselected flash sees a quiet clock
    sck_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        fls_ncs |-> $stable(fls_sck))
        else
        begin
            $error("SCK changed while chip select was high");
            fail_cnt = fail_cnt + 1;
        end

    // Selected only during a read
    ncs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !fls_ncs |-> busy)
        else
        begin
            $error("chip select low while the reader was idle");
            fail_cnt = fail_cnt + 1;
        end

    // One strobe per byte
    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid)
        else
        begin
            $error("byte_valid held for more than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    // No stale done at the start of a read
    done_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> !done)
        else
        begin
            $error("done high while busy rose");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind flash_boot_top flash_boot_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .fls_sck    (fls_sck),
    .fls_ncs    (fls_ncs),
    .busy       (busy),
    .byte_valid (byte_valid),
    .done       (done)
);

// File: flash_boot_top.sv
`timescale 1ns/1ps

module flash_boot_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  flash_pkg::flash_addr_t start_addr,
    input  flash_pkg::byte_count_t byte_count,
    input  logic                   fls_sdi,
    output logic                   fls_sck,
    output logic                   fls_ncs,
    output logic                   fls_sdo,
    output logic                   busy,
    output logic                   byte_valid,
    output flash_pkg::flash_addr_t byte_addr,
    output flash_pkg::flash_byte_t byte_data,
    output logic                   done,
    output flash_pkg::crc16_t      crc
);

    // Engine to checker
    flash_stream_if stream ();

    // SPI fast read engine
    flash_fast_read u_read (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .start_addr (start_addr),
        .byte_count (byte_count),
        .fls_sck    (fls_sck),
        .fls_ncs    (fls_ncs),
        .fls_sdo    (fls_sdo),
        .fls_sdi    (fls_sdi),
        .busy       (busy),
        .stream     (stream.src)
    );

    // CRC over the image
    flash_image_check u_check (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .stream (stream.dst),
        .done   (done),
        .crc    (crc)
    );

    // Stream out to the boot logic
    assign byte_valid = stream.valid;
    assign byte_addr  = stream.addr;
    assign byte_data  = stream.data;

endmodule

// File: flash_fast_read.sv
`timescale 1ns/1ps

module flash_fast_read (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  flash_pkg::flash_addr_t start_addr,
    input  flash_pkg::byte_count_t byte_count,
    output logic                   fls_sck,
    output logic                   fls_ncs,
    output logic                   fls_sdo,
    input  logic                   fls_sdi,
    output logic                   busy,
    flash_stream_if.src            stream
);

    flash_pkg::read_state_t         state;
    logic [2:0]                     phase;
    logic [4:0]                     bit_cnt;
    logic [flash_pkg::CMD_BITS-1:0] tx_sr;
    flash_pkg::flash_byte_t         rx_sr;
    flash_pkg::byte_count_t         remaining;
    flash_pkg::flash_addr_t         addr_reg;
    logic                           running;
    logic                           period_end;
    logic                           sample_pt;
    logic                           byte_end;

    // SCK toggles only in these states
    assign running = (state == flash_pkg::CMD) || (state == flash_pkg::DUMMY) ||
                     (state == flash_pkg::DATA);

    // Last phase of an SCK period
    assign period_end = (phase == 3'(flash_pkg::SCK_DIV - 1));

    // First phase with SCK high, rising edge just seen by the flash
    assign sample_pt = (state == flash_pkg::DATA) && (phase == 3'(flash_pkg::SCK_DIV / 2));

    // Sample of bit 7, byte is complete
    assign byte_end = sample_pt && (bit_cnt == 5'($bits(flash_pkg::flash_byte_t) - 1));

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= flash_pkg::IDLE;
            phase     <= '0;
            bit_cnt   <= '0;
            busy      <= 1'b0;
            fls_ncs   <= 1'b1;
            remaining <= '0;
        end
        else
        begin
            case (state)
                flash_pkg::IDLE:
                begin
                    // Zero length read is dropped here
                    if (start && (byte_count != '0))
                    begin
                        state     <= flash_pkg::CMD;
                        busy      <= 1'b1;
                        fls_ncs   <= 1'b0;
                        phase     <= '0;
                        bit_cnt   <= '0;
                        remaining <= byte_count;
                    end
                end
                flash_pkg::CMD:
                begin
                    phase <= phase + 3'd1;
                    if (period_end)
                    begin
                        // Opcode and address done
                        if (bit_cnt == 5'(flash_pkg::CMD_BITS - 1))
                        begin
                            state   <= flash_pkg::DUMMY;
                            bit_cnt <= '0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                flash_pkg::DUMMY:
                begin
                    phase <= phase + 3'd1;
                    if (period_end)
                    begin
                        if (bit_cnt == 5'(flash_pkg::DUMMY_CLKS - 1))
                        begin
                            state   <= flash_pkg::DATA;
                            bit_cnt <= '0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                flash_pkg::DATA:
                begin
                    phase <= phase + 3'd1;
                    if (byte_end)
                        remaining <= remaining - 16'd1;
                    if (period_end)
                    begin
                        if (bit_cnt == 5'($bits(flash_pkg::flash_byte_t) - 1))
                        begin
                            bit_cnt <= '0;
                            // Count already stepped at the sample point
                            if (remaining == '0)
                                state <= flash_pkg::DONE;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                flash_pkg::DONE:
                begin
                    // SCK is already low, deselect the flash for two periods
                    phase   <= phase + 3'd1;
                    fls_ncs <= 1'b1;
                    if (period_end)
                    begin
                        if (bit_cnt == 5'd1)
                        begin
                            state   <= flash_pkg::IDLE;
                            busy    <= 1'b0;
                            bit_cnt <= '0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                    end
                end
                default:
                begin
                    state <= flash_pkg::IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // SPI pins
    //////////////////////////////

    // Registered one phase early, so SCK is high in phases 4 to 7
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            fls_sck <= 1'b0;
        else
            fls_sck <= running && (phase >= 3'(flash_pkg::SCK_DIV / 2 - 1)) && !period_end;
    end

    // SDO moves in phase 0, well before the rising edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            fls_sdo <= 1'b0;
        else if (running && (phase == 3'd0))
            fls_sdo <= tx_sr[flash_pkg::CMD_BITS-1];
    end

    // Command shifter, MSB first, empties to zero for the dummy phase
    always_ff @(posedge clk)
    begin
        if ((state == flash_pkg::IDLE) && start)
            tx_sr <= {flash_pkg::FAST_READ_OP, start_addr};
        else if (running && (phase == 3'd0))
            tx_sr <= {tx_sr[flash_pkg::CMD_BITS-2:0], 1'b0};
    end

    // Receive shifter
    always_ff @(posedge clk)
    begin
        if (sample_pt)
            rx_sr <= {rx_sr[6:0], fls_sdi};
    end

    //////////////////////////////
    // Byte stream
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
        end
        else
        begin
            stream.valid <= byte_end;
            stream.last  <= byte_end && (remaining == 16'd1);
        end
    end

    // Address wraps past the top of the device
    always_ff @(posedge clk)
    begin
        if ((state == flash_pkg::IDLE) && start)
        begin
            addr_reg <= start_addr;
        end
        else if (byte_end)
        begin
            stream.addr <= addr_reg;
            stream.data <= {rx_sr[6:0], fls_sdi};
            addr_reg    <= addr_reg + 24'd1;
        end
    end

endmodule

// File: flash_image_check.sv
`timescale 1ns/1ps

module flash_image_check (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    flash_stream_if.dst       stream,
    output logic              done,
    output flash_pkg::crc16_t crc
);

    // Bytes seen so far in the current image
    flash_pkg::byte_count_t byte_cnt;

    // One byte into the CRC, MSB first
    function automatic flash_pkg::crc16_t crc_step(input flash_pkg::crc16_t c,
                                                   input flash_pkg::flash_byte_t d);
        flash_pkg::crc16_t r;
        int                i;
        r = c ^ {d, 8'h00};
        for (i = 0; i < 8; i++)
        begin
            if (r[15])
                r = {r[14:0], 1'b0} ^ flash_pkg::CRC_POLY;
            else
                r = {r[14:0], 1'b0};
        end
        return r;
    endfunction

    //////////////////////////////
    // Image tracking
    //////////////////////////////

    // Back to zero after the last byte
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            byte_cnt <= '0;
        else if (stream.valid)
            byte_cnt <= stream.last ? '0 : byte_cnt + 16'd1;
    end

    // A start in the middle of an image leaves the CRC alone
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= flash_pkg::CRC_INIT;
        else if (stream.valid)
            crc <= crc_step(crc, stream.data);
        else if (start && (byte_cnt == '0))
            crc <= flash_pkg::CRC_INIT;
    end

    // Final CRC is on crc in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= stream.valid && stream.last;
    end

endmodule

// File: flash_pkg.sv
package flash_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // Flash byte address, 16 MB device
    typedef logic [23:0] flash_addr_t;

    // One data byte from the flash
    typedef logic [7:0] flash_byte_t;

    // Number of bytes in one read
    typedef logic [15:0] byte_count_t;

    // CRC-16 value
    typedef logic [15:0] crc16_t;

    // Read engine sequencing
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        DUMMY,
        DATA,
        DONE
    } read_state_t;

    //////////////////////////////
    // SPI timing and command
    //////////////////////////////

    // System clocks per SCK period
    localparam int SCK_DIV = 8;

    // Fast read opcode, then 24 address bits
    localparam flash_byte_t FAST_READ_OP = 8'h0B;
    localparam int CMD_BITS = 32;
    localparam int DUMMY_CLKS = 8;

    // CRC-16/CCITT-FALSE
    localparam crc16_t CRC_POLY = 16'h1021;
    localparam crc16_t CRC_INIT = 16'hFFFF;

endpackage

// File: flash_stream_if.sv
`timescale 1ns/1ps

// Byte stream from the read engine to its consumers
// No ready, every byte is taken in the cycle it is offered
interface flash_stream_if;

    // One-cycle strobe per byte
    logic                   valid;

    // Address the byte was read from
    flash_pkg::flash_addr_t addr;

    // The byte itself
    flash_pkg::flash_byte_t data;

    // Final byte of the read, only with valid
    logic                   last;

    modport src (output valid, output addr, output data, output last);

    modport dst (input valid, input addr, input data, input last);

endinterface

// File: spi_flash_model.sv
`timescale 1ns/1ps

// Mode 0 SPI NOR flash, fast read only
// Byte at address a is a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5
module spi_flash_model (
    input  logic fls_sck,
    input  logic fls_ncs,
    input  logic fls_sdo,
    output logic fls_sdi,
    output logic bad_opcode
);

    // Opcode, address and dummy clocks before the first data bit
    localparam int HDR_EDGES = flash_pkg::CMD_BITS + flash_pkg::DUMMY_CLKS;

    int                     edge_cnt = 0;
    logic [31:0]            cmd_sr = '0;
    flash_pkg::flash_addr_t base = '0;
    logic                   opcode_err = 1'b0;
    logic                   sdi_q = 1'b0;
    int                     idx;
    flash_pkg::flash_byte_t cur;
    logic [2:0]             bit_sel;

    assign fls_sdi    = sdi_q;
    assign bad_opcode = opcode_err;

    function automatic flash_pkg::flash_byte_t content(input flash_pkg::flash_addr_t a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
    endfunction

    // Command in on rising SCK, deselect restarts the command
    always @(posedge fls_sck or posedge fls_ncs)
    begin
        if (fls_ncs)
        begin
            edge_cnt <= 0;
        end
        else
        begin
            if (edge_cnt < flash_pkg::CMD_BITS)
                cmd_sr <= {cmd_sr[30:0], fls_sdo};
            // Eighth edge closes the opcode
            if ((edge_cnt == 7) && ({cmd_sr[6:0], fls_sdo} != flash_pkg::FAST_READ_OP))
                opcode_err <= 1'b1;
            // Last address bit
            if (edge_cnt == flash_pkg::CMD_BITS - 1)
                base <= {cmd_sr[22:0], fls_sdo};
            edge_cnt <= edge_cnt + 1;
        end
    end

    // Data out on falling SCK, MSB first, address counts up and wraps
    always @(negedge fls_sck)
    begin
        if (!fls_ncs && (edge_cnt >= HDR_EDGES))
        begin
            idx     = edge_cnt - HDR_EDGES;
            cur     = content(base + 24'(idx / 8));
            bit_sel = 3'(7 - (idx % 8));
            sdi_q  <= cur[bit_sel];
        end
    end

endmodule

// File: tb_flash_boot.sv
`timescale 1ns/1ps

module tb_flash_boot;

    localparam int RAND_READS = 6;
    localparam int NUM_READS = RAND_READS + 4;
    localparam int BYTE_CLKS = 8 * flash_pkg::SCK_DIV;
    localparam flash_pkg::flash_addr_t WRAP_ADDR = 24'hFFFFF8;
    localparam flash_pkg::byte_count_t WRAP_COUNT = 16'd16;
    localparam flash_pkg::byte_count_t BUSY_COUNT = 16'd20;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    flash_pkg::flash_addr_t start_addr;
    flash_pkg::byte_count_t byte_count;
    logic                   fls_sdi;
    logic                   fls_sck;
    logic                   fls_ncs;
    logic                   fls_sdo;
    logic                   busy;
    logic                   byte_valid;
    flash_pkg::flash_addr_t byte_addr;
    flash_pkg::flash_byte_t byte_data;
    logic                   done;
    flash_pkg::crc16_t      crc;
    logic                   bad_opcode;

    // Request set by the stimulus process
    string                  test_name = "reset_state";
    flash_pkg::flash_addr_t req_addr = '0;
    flash_pkg::byte_count_t req_count = '0;
    int                     req_seq = 0;
    logic [31:0]            lfsr = 32'h93092f61;
    logic                   plan_ready = 1'b0;
    int                     limit_cycles = 0;

    // Expected stream kept by the compare process
    int                     seen_seq = 0;
    int                     done_cnt = 0;
    flash_pkg::flash_addr_t exp_addr = '0;
    int                     exp_left = 0;
    flash_pkg::crc16_t      exp_crc = '0;
    logic                   done_pending = 1'b0;

    always #20 clk = ~clk;

    flash_boot_top UUT (
        .clk(clk), .rst_n(rst_n), .start(start), .start_addr(start_addr),
        .byte_count(byte_count), .fls_sdi(fls_sdi), .fls_sck(fls_sck),
        .fls_ncs(fls_ncs), .fls_sdo(fls_sdo), .busy(busy), .byte_valid(byte_valid),
        .byte_addr(byte_addr), .byte_data(byte_data), .done(done), .crc(crc)
    );

    spi_flash_model u_flash (
        .fls_sck(fls_sck), .fls_ncs(fls_ncs), .fls_sdo(fls_sdo),
        .fls_sdi(fls_sdi), .bad_opcode(bad_opcode)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic flash_pkg::flash_byte_t flash_byte(input flash_pkg::flash_addr_t a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
    endfunction

    // CRC-16/CCITT-FALSE one bit at a time
    function automatic flash_pkg::crc16_t crc_range(input flash_pkg::flash_addr_t a,
                                                    input int n);
        flash_pkg::crc16_t      c;
        flash_pkg::flash_byte_t d;
        flash_pkg::flash_addr_t p;
        logic                   fb;
        c = flash_pkg::CRC_INIT;
        p = a;
        for (int k = 0; k < n; k++)
        begin
            d = flash_byte(p);
            for (int b = 0; b < 8; b++)
            begin
                fb = c[15] ^ d[7];
                d  = {d[6:0], 1'b0};
                c  = {c[14:0], 1'b0};
                if (fb)
                    c = c ^ flash_pkg::CRC_POLY;
            end
            p = p + 24'd1;
        end
        return c;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    //////////////////////////////
    // Error reporting
    //////////////////////////////

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
        stop_on_error();
    endtask

    task automatic fail_text(input string msg);
        $display("%s in %s", msg, test_name);
        stop_on_error();
    endtask

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic pulse_start(input flash_pkg::flash_addr_t a, input flash_pkg::byte_count_t n);
        @(posedge clk);
        start      <= 1'b1;
        start_addr <= a;
        byte_count <= n;
        @(posedge clk);
        start      <= 1'b0;
    endtask

    task automatic begin_read(input string name, input flash_pkg::flash_addr_t a,
                              input flash_pkg::byte_count_t n);
        @(posedge clk);
        test_name = name;
        req_addr  = a;
        req_count = n;
        req_seq   = req_seq + 1;
        start      <= 1'b1;
        start_addr <= a;
        byte_count <= n;
        @(posedge clk);
        start      <= 1'b0;
        @(negedge clk);
        assert (busy) else fail_value("busy", 32'd1, 32'(busy));
    endtask

    // Done seen by the compare process, then back to idle
    task automatic finish_read();
        while (done_cnt != req_seq)
            @(posedge clk);
        do
            @(negedge clk);
        while (busy);
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (!bad_opcode) else fail_text("Flash model saw a wrong opcode");
            assert (UUT.u_props.fail_cnt == 0)
                else fail_text("An SPI pin or stream property failed");
            if (req_seq != seen_seq)
            begin
                seen_seq     = req_seq;
                exp_addr     = req_addr;
                exp_left     = int'(req_count);
                exp_crc      = crc_range(req_addr, exp_left);
                done_pending = 1'b1;
            end
            if (byte_valid)
            begin
                assert (exp_left > 0) else fail_text("Byte arrived with none expected");
                assert (byte_addr == exp_addr)
                    else fail_value("byte_addr", 32'(exp_addr), 32'(byte_addr));
                assert (byte_data == flash_byte(exp_addr))
                    else fail_value("byte_data", 32'(flash_byte(exp_addr)), 32'(byte_data));
                exp_addr = exp_addr + 24'd1;
                exp_left = exp_left - 1;
            end
            if (done)
            begin
                assert (done_pending) else fail_text("done pulsed with no read open");
                assert (exp_left == 0) else fail_value("bytes missing at done", 0, exp_left);
                assert (crc == exp_crc) else fail_value("crc", 32'(exp_crc), 32'(crc));
                done_pending = 1'b0;
                done_cnt     = done_cnt + 1;
            end
        end
    end

    // Byte time per byte, 60 SCK periods per read, plus margin
    initial
    begin
        wait (plan_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d clock cycles in %s", limit_cycles, test_name);
        stop_on_error();
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        flash_pkg::flash_addr_t rnd_addr [RAND_READS];
        flash_pkg::byte_count_t rnd_count [RAND_READS];
        logic [31:0]            r;
        int                     total;
        rst_n      <= 1'b0;
        start      <= 1'b0;
        start_addr <= '0;
        byte_count <= '0;

        // Random reads drawn up front so the watchdog knows the length
        total = 1 + int'(WRAP_COUNT) + int'(BUSY_COUNT);
        for (int i = 0; i < RAND_READS; i++)
        begin
            draw_bits(24, r);
            rnd_addr[i] = r[23:0];
            draw_bits(6, r);
            rnd_count[i] = 16'(r % 32'd40) + 16'd1;
            total = total + int'(rnd_count[i]);
        end
        limit_cycles = total * BYTE_CLKS + NUM_READS * 60 * flash_pkg::SCK_DIV + 500;
        plan_ready = 1'b1;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Idle pins after reset
        @(negedge clk);
        assert (fls_ncs) else fail_value("fls_ncs", 32'd1, 32'(fls_ncs));
        assert (!fls_sck) else fail_value("fls_sck", 32'd0, 32'(fls_sck));
        assert (!busy) else fail_value("busy", 32'd0, 32'(busy));
        assert (!byte_valid) else fail_value("byte_valid", 32'd0, 32'(byte_valid));
        assert (!done) else fail_value("done", 32'd0, 32'(done));

        begin_read("single_byte", 24'h000000, 16'd1);
        finish_read();

        for (int i = 0; i < RAND_READS; i++)
        begin
            begin_read($sformatf("random_read_%0d", i), rnd_addr[i], rnd_count[i]);
            finish_read();
        end

        begin_read("address_wrap", WRAP_ADDR, WRAP_COUNT);
        finish_read();

        // Extra starts in the command phase and between data bytes
        begin_read("start_while_busy", 24'h3C5A00, BUSY_COUNT);
        repeat (10 * flash_pkg::SCK_DIV) @(posedge clk);
        pulse_start(24'h000100, 16'd3);
        do
            @(negedge clk);
        while (!byte_valid);
        pulse_start(24'h00ABCD, 16'd5);
        finish_read();

        // Zero length start leaves the reader idle
        test_name = "zero_count";
        pulse_start(24'h123456, 16'd0);
        // Window covers the first byte and done of a wrongly started read
        repeat ((flash_pkg::CMD_BITS + flash_pkg::DUMMY_CLKS + 10) * flash_pkg::SCK_DIV)
        begin
            @(negedge clk);
            assert (!busy) else fail_value("busy", 32'd0, 32'(busy));
            assert (fls_ncs) else fail_value("fls_ncs", 32'd1, 32'(fls_ncs));
        end

        // Bound properties may have failed on the last edges
        if (UUT.u_props.fail_cnt == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            fail_text("An SPI pin or stream property failed");
        end
    end

endmodule
